// File: Makefile
# Verilator lint and simulation of the data cache

VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= *** PASSED ***

SOURCES := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cache_ctrl/cache_ctrl.sv
// blocking cache controller: request latch, hit combine, victim choice, write-back and refill FSM

`timescale 1ns/1ps

module cache_ctrl (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  // cpu side
  input  logic                                 i_valid,       // one cycle strobe
  input  logic                                 i_op,          // 1 = store
  input  logic [dcache_pkg::ADDR_W-1:0]        i_addr,
  input  logic [dcache_pkg::STRB_W-1:0]        i_wstrb,
  input  logic [dcache_pkg::DATA_W-1:0]        i_wdata,
  output logic                                 o_busy,
  output logic                                 o_data_ok,
  output logic [dcache_pkg::DATA_W-1:0]        o_rdata,
  // from the way banks
  input  logic [dcache_pkg::WAYS-1:0]          i_hit,
  input  logic [dcache_pkg::WAYS-1:0]          i_way_valid,
  input  logic [dcache_pkg::WAYS-1:0]          i_way_dirty,
  input  logic [dcache_pkg::TAG_W-1:0]         i_way_tag0,
  input  logic [dcache_pkg::TAG_W-1:0]         i_way_tag1,
  input  logic [dcache_pkg::LINE_W-1:0]        i_way_line0,
  input  logic [dcache_pkg::LINE_W-1:0]        i_way_line1,
  // to the way banks
  output logic [dcache_pkg::INDEX_W-1:0]       o_index,
  output logic [dcache_pkg::TAG_W-1:0]         o_req_tag,
  output logic [dcache_pkg::WAYS-1:0]          o_store_en,
  output logic [dcache_pkg::BEAT_W-1:0]        o_word_sel,
  output logic [dcache_pkg::STRB_W-1:0]        o_wstrb,
  output logic [dcache_pkg::DATA_W-1:0]        o_wdata,
  output logic [dcache_pkg::WAYS-1:0]          o_beat_en,
  output logic [dcache_pkg::BEAT_W-1:0]        o_beat_sel,
  output logic [dcache_pkg::DATA_W-1:0]        o_beat_data,
  output logic [dcache_pkg::WAYS-1:0]          o_fill_done,
  // memory read channel
  output logic                                 o_rd_req,
  output logic [dcache_pkg::ADDR_W-1:0]        o_rd_addr,
  input  logic                                 i_rd_rdy,
  input  logic                                 i_ret_valid,
  input  logic                                 i_ret_last,
  input  logic [dcache_pkg::DATA_W-1:0]        i_ret_data,
  // memory write channel
  output logic                                 o_wr_req,
  output logic [dcache_pkg::ADDR_W-1:0]        o_wr_addr,
  output logic [dcache_pkg::LINE_W-1:0]        o_wr_data,
  input  logic                                 i_wr_rdy
);

  dcache_pkg::cache_state_e          state_q;
  dcache_pkg::cache_state_e          state_d;

  // request latch
  dcache_pkg::cache_addr_u           req_addr_q;
  logic                              req_op_q;
  logic [dcache_pkg::STRB_W-1:0]     req_wstrb_q;
  logic [dcache_pkg::DATA_W-1:0]     req_wdata_q;

  // miss bookkeeping
  logic                              victim_q;
  logic [dcache_pkg::BEAT_W-1:0]     beat_cnt_q;
  logic [dcache_pkg::SETS-1:0]       rr_q;           // round-robin bit per set

  logic                              accept;
  logic                              lookup;
  logic                              any_hit;
  logic                              victim_d;
  logic                              beat_go;
  logic                              fill_go;
  logic [dcache_pkg::LINE_W-1:0]     hit_line;
  logic [dcache_pkg::TAG_W-1:0]      victim_tag;
  dcache_pkg::cache_addr_u           rd_addr;
  dcache_pkg::cache_addr_u           wr_addr;

  assign accept  = (state_q == dcache_pkg::IDLE) && i_valid;
  assign lookup  = (state_q == dcache_pkg::LOOKUP);
  assign any_hit = |i_hit;
  assign beat_go = (state_q == dcache_pkg::REFILL) && i_ret_valid;
  assign fill_go = beat_go && i_ret_last;

  // --------------------------------------------------
  // victim choice, invalid way first
  // --------------------------------------------------
  always_comb begin
    if (!i_way_valid[0]) begin
      victim_d = 1'b0;
    end else if (!i_way_valid[1]) begin
      victim_d = 1'b1;
    end else begin
      victim_d = rr_q[req_addr_q.f.index];
    end
  end

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_pkg::IDLE: begin
        if (i_valid) state_d = dcache_pkg::LOOKUP;
      end
      dcache_pkg::LOOKUP: begin
        if (any_hit) begin
          state_d = dcache_pkg::IDLE;
        end else if (i_way_valid[victim_d] && i_way_dirty[victim_d]) begin
          state_d = dcache_pkg::WRITEBACK;
        end else begin
          state_d = dcache_pkg::REFILL_REQ;
        end
      end
      dcache_pkg::WRITEBACK: begin
        if (i_wr_rdy) state_d = dcache_pkg::REFILL_REQ;
      end
      dcache_pkg::REFILL_REQ: begin
        if (i_rd_rdy) state_d = dcache_pkg::REFILL;
      end
      dcache_pkg::REFILL: begin
        if (fill_go) state_d = dcache_pkg::LOOKUP;   // replay, now hits
      end
      default: state_d = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q    <= dcache_pkg::IDLE;
      victim_q   <= 1'b0;
      beat_cnt_q <= '0;
      rr_q       <= '0;
    end else begin
      state_q <= state_d;
      if (lookup && !any_hit) victim_q <= victim_d;  // held for the whole miss
      if (state_q == dcache_pkg::REFILL_REQ) begin
        beat_cnt_q <= '0;
      end else if (beat_go) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      if (fill_go) rr_q[req_addr_q.f.index] <= ~rr_q[req_addr_q.f.index];
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_addr_q.word <= i_addr;
      req_op_q        <= i_op;
      req_wstrb_q     <= i_wstrb;
      req_wdata_q     <= i_wdata;
    end
  end

  // --------------------------------------------------
  // cpu response and bank steering
  // --------------------------------------------------
  assign hit_line  = i_hit[1] ? i_way_line1 : i_way_line0;
  assign o_busy    = (state_q != dcache_pkg::IDLE);
  assign o_data_ok = lookup && any_hit;
  assign o_rdata   = hit_line[int'(o_word_sel)*dcache_pkg::DATA_W +: dcache_pkg::DATA_W];

  assign o_index     = req_addr_q.f.index;
  assign o_req_tag   = req_addr_q.f.tag;
  assign o_word_sel  = req_addr_q.f.offset[dcache_pkg::OFFSET_W-1 -: dcache_pkg::BEAT_W];
  assign o_wstrb     = req_wstrb_q;
  assign o_wdata     = req_wdata_q;
  assign o_store_en  = (lookup && req_op_q) ? i_hit : '0;   // written at the end of lookup
  assign o_beat_en   = beat_go ? {victim_q, ~victim_q} : '0;
  assign o_beat_sel  = beat_cnt_q;
  assign o_beat_data = i_ret_data;
  assign o_fill_done = fill_go ? {victim_q, ~victim_q} : '0;

  // --------------------------------------------------
  // memory bus, line aligned addresses
  // --------------------------------------------------
  assign victim_tag = victim_q ? i_way_tag1 : i_way_tag0;

  always_comb begin
    rd_addr.f.tag    = req_addr_q.f.tag;
    rd_addr.f.index  = req_addr_q.f.index;
    rd_addr.f.offset = '0;
    wr_addr.f.tag    = victim_tag;                    // victim's own line
    wr_addr.f.index  = req_addr_q.f.index;
    wr_addr.f.offset = '0;
  end

  assign o_rd_req  = (state_q == dcache_pkg::REFILL_REQ);
  assign o_rd_addr = rd_addr.word;
  assign o_wr_req  = (state_q == dcache_pkg::WRITEBACK);
  assign o_wr_addr = wr_addr.word;
  assign o_wr_data = victim_q ? i_way_line1 : i_way_line0;

endmodule

// File: cache_way/cache_way_bank.sv
// one way of the data cache: tag, valid, dirty and line storage with the hit compare, one per way

`timescale 1ns/1ps

module cache_way_bank (
  input  logic                             i_clk,
  input  logic                             i_rst,
  // lookup
  input  logic [dcache_pkg::INDEX_W-1:0]   i_index,       // set under access
  input  logic [dcache_pkg::TAG_W-1:0]     i_tag,         // request tag
  // store hit
  input  logic                             i_store_en,
  input  logic [dcache_pkg::BEAT_W-1:0]    i_word_sel,
  input  logic [dcache_pkg::STRB_W-1:0]    i_wstrb,
  input  logic [dcache_pkg::DATA_W-1:0]    i_wdata,
  // refill
  input  logic                             i_beat_en,
  input  logic [dcache_pkg::BEAT_W-1:0]    i_beat_sel,
  input  logic [dcache_pkg::DATA_W-1:0]    i_beat_data,
  input  logic                             i_fill_done,   // last beat, line now owned
  // lookup results
  output logic                             o_hit,
  output logic                             o_valid,
  output logic                             o_dirty,
  output logic [dcache_pkg::TAG_W-1:0]     o_tag,
  output logic [dcache_pkg::LINE_W-1:0]    o_line
);

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  logic [dcache_pkg::TAG_W-1:0]  tag_q   [dcache_pkg::SETS];
  logic [dcache_pkg::LINE_W-1:0] line_q  [dcache_pkg::SETS];
  logic [dcache_pkg::SETS-1:0]   valid_q;
  logic [dcache_pkg::SETS-1:0]   dirty_q;

  // --------------------------------------------------
  // read side, all combinational from the index
  // --------------------------------------------------
  assign o_tag   = tag_q[i_index];
  assign o_line  = line_q[i_index];
  assign o_valid = valid_q[i_index];
  assign o_dirty = dirty_q[i_index];
  assign o_hit   = valid_q[i_index] && (tag_q[i_index] == i_tag);

  // --------------------------------------------------
  // line state bits
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (i_fill_done) begin
        valid_q[i_index] <= 1'b1;
        dirty_q[i_index] <= 1'b0;                          // fresh copy of memory
      end else if (i_store_en) begin
        dirty_q[i_index] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // tag and line data
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_fill_done) begin
      tag_q[i_index] <= i_tag;
    end

    // refill writes a whole word per beat
    if (i_beat_en) begin
      line_q[i_index][int'(i_beat_sel)*dcache_pkg::DATA_W +: dcache_pkg::DATA_W]
        <= i_beat_data;
    end

    // store merges only the strobed bytes
    if (i_store_en) begin
      for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
        if (i_wstrb[b]) begin
          line_q[i_index][int'(i_word_sel)*dcache_pkg::DATA_W + b*8 +: 8]
            <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: common/dcache_pkg.sv
// shared geometry, controller states and address decode for the data cache; use by scoped name

package dcache_pkg;

  // --------------------------------------------------
  // cpu port widths
  // --------------------------------------------------
  localparam int ADDR_W     = 32;                  // byte address
  localparam int DATA_W     = 64;                  // one cpu word
  localparam int STRB_W     = DATA_W / 8;          // byte strobes per word

  // --------------------------------------------------
  // cache geometry
  // --------------------------------------------------
  localparam int LINE_BYTES = 32;
  localparam int LINE_W     = LINE_BYTES * 8;      // 256 bit line
  localparam int BEATS      = LINE_W / DATA_W;     // burst length on the line bus
  localparam int BEAT_W     = $clog2(BEATS);       // beat counter and word select
  localparam int SETS       = 64;
  localparam int INDEX_W    = $clog2(SETS);
  localparam int OFFSET_W   = $clog2(LINE_BYTES);
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAYS       = 2;

  // --------------------------------------------------
  // controller FSM
  // --------------------------------------------------
  typedef enum logic [2:0] {
    IDLE       = 3'd0,                             // waiting for a cpu strobe
    LOOKUP     = 3'd1,                             // tag compare on both ways
    WRITEBACK  = 3'd2,                             // dirty victim out to memory
    REFILL_REQ = 3'd3,                             // line read request held
    REFILL     = 3'd4                              // collecting return beats
  } cache_state_e;

  // --------------------------------------------------
  // address word, raw or split into lookup fields
  // --------------------------------------------------
  typedef union packed {
    logic [ADDR_W-1:0] word;                       // as driven onto the memory bus
    struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;                 // [4:3] word, [2:0] byte
    } f;
  } cache_addr_u;

endpackage

// File: flist.f
common/dcache_pkg.sv
cache_way/cache_way_bank.sv
cache_ctrl/cache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_assertions.sv
testbench/tb_dcache.sv

// File: hdl/dcache_top.sv
// two-way write-back data cache top; connects the way banks to the controller, CPU and line bus

`timescale 1ns/1ps

module dcache_top (
  input  logic                              i_clk,
  input  logic                              i_rst,
  // cpu side
  input  logic                              i_valid,
  input  logic                              i_op,
  input  logic [dcache_pkg::ADDR_W-1:0]     i_addr,
  input  logic [dcache_pkg::STRB_W-1:0]     i_wstrb,
  input  logic [dcache_pkg::DATA_W-1:0]     i_wdata,
  output logic                              o_busy,
  output logic                              o_data_ok,
  output logic [dcache_pkg::DATA_W-1:0]     o_rdata,
  // memory read channel
  output logic                              o_rd_req,
  output logic [dcache_pkg::ADDR_W-1:0]     o_rd_addr,
  input  logic                              i_rd_rdy,
  input  logic                              i_ret_valid,
  input  logic                              i_ret_last,
  input  logic [dcache_pkg::DATA_W-1:0]     i_ret_data,
  // memory write channel
  output logic                              o_wr_req,
  output logic [dcache_pkg::ADDR_W-1:0]     o_wr_addr,
  output logic [dcache_pkg::LINE_W-1:0]     o_wr_data,
  input  logic                              i_wr_rdy
);

  // --------------------------------------------------
  // controller to banks
  // --------------------------------------------------
  logic [dcache_pkg::INDEX_W-1:0]  index;
  logic [dcache_pkg::TAG_W-1:0]    req_tag;
  logic [dcache_pkg::WAYS-1:0]     store_en;
  logic [dcache_pkg::BEAT_W-1:0]   word_sel;
  logic [dcache_pkg::STRB_W-1:0]   way_wstrb;
  logic [dcache_pkg::DATA_W-1:0]   way_wdata;
  logic [dcache_pkg::WAYS-1:0]     beat_en;
  logic [dcache_pkg::BEAT_W-1:0]   beat_sel;
  logic [dcache_pkg::DATA_W-1:0]   beat_data;
  logic [dcache_pkg::WAYS-1:0]     fill_done;

  // --------------------------------------------------
  // banks to controller
  // --------------------------------------------------
  logic [dcache_pkg::WAYS-1:0]     hit;
  logic [dcache_pkg::WAYS-1:0]     way_valid;
  logic [dcache_pkg::WAYS-1:0]     way_dirty;
  logic [dcache_pkg::TAG_W-1:0]    way_tag0;
  logic [dcache_pkg::TAG_W-1:0]    way_tag1;
  logic [dcache_pkg::LINE_W-1:0]   way_line0;
  logic [dcache_pkg::LINE_W-1:0]   way_line1;

  cache_way_bank u_way0 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_index     (index),
    .i_tag       (req_tag),
    .i_store_en  (store_en[0]),
    .i_word_sel  (word_sel),
    .i_wstrb     (way_wstrb),
    .i_wdata     (way_wdata),
    .i_beat_en   (beat_en[0]),
    .i_beat_sel  (beat_sel),
    .i_beat_data (beat_data),
    .i_fill_done (fill_done[0]),
    .o_hit       (hit[0]),
    .o_valid     (way_valid[0]),
    .o_dirty     (way_dirty[0]),
    .o_tag       (way_tag0),
    .o_line      (way_line0)
  );

  cache_way_bank u_way1 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_index     (index),
    .i_tag       (req_tag),
    .i_store_en  (store_en[1]),
    .i_word_sel  (word_sel),
    .i_wstrb     (way_wstrb),
    .i_wdata     (way_wdata),
    .i_beat_en   (beat_en[1]),
    .i_beat_sel  (beat_sel),
    .i_beat_data (beat_data),
    .i_fill_done (fill_done[1]),
    .o_hit       (hit[1]),
    .o_valid     (way_valid[1]),
    .o_dirty     (way_dirty[1]),
    .o_tag       (way_tag1),
    .o_line      (way_line1)
  );

  cache_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_op        (i_op),
    .i_addr      (i_addr),
    .i_wstrb     (i_wstrb),
    .i_wdata     (i_wdata),
    .o_busy      (o_busy),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .i_hit       (hit),
    .i_way_valid (way_valid),
    .i_way_dirty (way_dirty),
    .i_way_tag0  (way_tag0),
    .i_way_tag1  (way_tag1),
    .i_way_line0 (way_line0),
    .i_way_line1 (way_line1),
    .o_index     (index),
    .o_req_tag   (req_tag),
    .o_store_en  (store_en),
    .o_word_sel  (word_sel),
    .o_wstrb     (way_wstrb),
    .o_wdata     (way_wdata),
    .o_beat_en   (beat_en),
    .o_beat_sel  (beat_sel),
    .o_beat_data (beat_data),
    .o_fill_done (fill_done),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data),
    .o_wr_req    (o_wr_req),
    .o_wr_addr   (o_wr_addr),
    .o_wr_data   (o_wr_data),
    .i_wr_rdy    (i_wr_rdy)
  );

endmodule

// File: testbench/dcache_assertions.sv
// protocol checks bound to cache_ctrl for its memory requests and cpu response

`timescale 1ns/1ps

module dcache_assertions (
  input logic                              i_clk,
  input logic                              i_rst,
  input logic                              i_rd_req,
  input logic [dcache_pkg::ADDR_W-1:0]     i_rd_addr,
  input logic                              i_rd_rdy,
  input logic                              i_wr_req,
  input logic [dcache_pkg::ADDR_W-1:0]     i_wr_addr,
  input logic [dcache_pkg::LINE_W-1:0]     i_wr_data,
  input logic                              i_wr_rdy,
  input logic                              i_data_ok
);

  int fails = 0;                                             // failed assertions so far

  // --------------------------------------------------
  // request hold until ready
  // --------------------------------------------------
  a_rd_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rd_req && !i_rd_rdy |=> i_rd_req && $stable(i_rd_addr))
    else begin
      fails = fails + 1;
      $error("read request dropped or its address moved before ready");
    end

  a_wr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wr_req && !i_wr_rdy |=> i_wr_req && $stable(i_wr_addr) && $stable(i_wr_data))
    else begin
      fails = fails + 1;
      $error("write-back request dropped or its address or line moved before ready");
    end

  // --------------------------------------------------
  // cpu response and channel exclusion
  // --------------------------------------------------
  a_ok_single: assert property (@(posedge i_clk) disable iff (i_rst)
      i_data_ok |=> !i_data_ok)
    else begin
      fails = fails + 1;
      $error("data_ok high in two cycles in a row");
    end

  a_one_channel: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_rd_req && i_wr_req))
    else begin
      fails = fails + 1;
      $error("read and write-back requests both high");
    end

endmodule

bind cache_ctrl dcache_assertions u_assertions (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_rd_req  (o_rd_req),
  .i_rd_addr (o_rd_addr),
  .i_rd_rdy  (i_rd_rdy),
  .i_wr_req  (o_wr_req),
  .i_wr_addr (o_wr_addr),
  .i_wr_data (o_wr_data),
  .i_wr_rdy  (i_wr_rdy),
  .i_data_ok (o_data_ok)
);

// File: testbench/tb_dcache.sv
// testbench for the data cache: line-bus memory model, byte reference model and directed tests

`timescale 1ns/1ps

module tb_dcache;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int RAND_ACCESS = 40;
  localparam int NUM_ACCESS  = 8 + RAND_ACCESS;              // directed plus random accesses

  logic                            i_clk;
  logic                            i_rst;
  logic                            i_valid;
  logic                            i_op;
  logic [dcache_pkg::ADDR_W-1:0]   i_addr;
  logic [dcache_pkg::STRB_W-1:0]   i_wstrb;
  logic [dcache_pkg::DATA_W-1:0]   i_wdata;
  logic                            o_busy;
  logic                            o_data_ok;
  logic [dcache_pkg::DATA_W-1:0]   o_rdata;
  logic                            o_rd_req;
  logic [dcache_pkg::ADDR_W-1:0]   o_rd_addr;
  logic                            i_rd_rdy;
  logic                            i_ret_valid;
  logic                            i_ret_last;
  logic [dcache_pkg::DATA_W-1:0]   i_ret_data;
  logic                            o_wr_req;
  logic [dcache_pkg::ADDR_W-1:0]   o_wr_addr;
  logic [dcache_pkg::LINE_W-1:0]   o_wr_data;
  logic                            i_wr_rdy;

  logic [7:0]   bus_mem [int unsigned];                      // bytes written back by the cache
  logic [7:0]   ref_mem [int unsigned];                      // what the cpu expects to read
  integer       seed = 51940;
  logic         rand_delay = 1'b0;                           // random ready and beat gaps
  int           value_errs = 0;
  int           other_errs = 0;
  int           rd_cnt = 0;
  int           wr_cnt = 0;
  int           seq = 0;
  int           rd_seq = 0;
  int           wr_seq = 0;
  logic [31:0]  last_rd_addr;
  logic [31:0]  last_wr_addr;
  logic [255:0] last_wr_data;

  dcache_top u_dcache_top (.*);

  initial begin : clock_gen
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // --------------------------------------------------
  // byte models
  // --------------------------------------------------
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;  // untouched memory
  endfunction

  function automatic logic [63:0] word_at(input logic from_ref, input logic [31:0] a);
    logic [63:0] w;
    logic [31:0] ab;
    for (int b = 0; b < 8; b++) begin
      ab = a + 32'(b);
      if (from_ref) begin
        w[b*8 +: 8] = ref_mem.exists(ab) ? ref_mem[ab] : fill_byte(ab);
      end else begin
        w[b*8 +: 8] = bus_mem.exists(ab) ? bus_mem[ab] : fill_byte(ab);
      end
    end
    return w;
  endfunction

  task automatic compare_word(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
    assert (act === exp)
    else begin
      value_errs++;
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic require(input string name, input logic cond, input string what);
    assert (cond)
    else begin
      other_errs++;
      $display("%0t [%s] %s", $time, name, what);
    end
  endtask

  // --------------------------------------------------
  // line bus memory
  // --------------------------------------------------
  task automatic idle_gap();
    repeat (rand_delay ? ($random(seed) & 3) : 0) begin
      @(posedge i_clk);
      #2;
    end
  endtask

  task automatic serve_write();
    logic [31:0]  a;
    logic [255:0] line;
    idle_gap();
    i_wr_rdy = 1'b1;
    a        = o_wr_addr;
    line     = o_wr_data;
    @(posedge i_clk);
    #2;
    i_wr_rdy = 1'b0;
    for (int i = 0; i < 32; i++) begin
      bus_mem[a + 32'(i)] = line[i*8 +: 8];
    end
    wr_cnt++;
    seq++;
    wr_seq       = seq;
    last_wr_addr = a;
    last_wr_data = line;
  endtask

  task automatic serve_read();
    logic [31:0] a;
    idle_gap();
    i_rd_rdy = 1'b1;
    a        = o_rd_addr;
    @(posedge i_clk);
    #2;
    i_rd_rdy = 1'b0;
    rd_cnt++;
    seq++;
    rd_seq       = seq;
    last_rd_addr = a;
    for (int k = 0; k < 4; k++) begin
      idle_gap();
      i_ret_valid = 1'b1;
      i_ret_last  = (k == 3);                                // fourth beat closes the burst
      i_ret_data  = word_at(1'b0, a + 32'(k * 8));
      @(posedge i_clk);
      #2;
      i_ret_valid = 1'b0;
      i_ret_last  = 1'b0;
    end
  endtask

  initial begin : memory_model
    @(posedge i_clk);
    #2;
    forever begin
      if (o_wr_req) begin
        serve_write();
      end else if (o_rd_req) begin
        serve_read();
      end else begin
        @(posedge i_clk);
        #2;
      end
    end
  end

  // --------------------------------------------------
  // cpu accesses and directed tests
  // --------------------------------------------------
  task automatic access(input string name, input logic op, input logic [31:0] addr,
                        input logic [7:0] strb, input logic [63:0] wdata, output int lat);
    while (o_busy) begin
      @(posedge i_clk);
      #2;
    end
    i_valid = 1'b1;
    i_op    = op;
    i_addr  = addr;
    i_wstrb = strb;
    i_wdata = wdata;
    if (op) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) ref_mem[addr + 32'(b)] = wdata[b*8 +: 8];
      end
    end
    @(posedge i_clk);                                        // accept edge
    #2;
    i_valid = 1'b0;
    lat     = 1;
    while (!o_data_ok) begin
      @(posedge i_clk);
      #2;
      lat++;
    end
    if (!op) compare_word(name, word_at(1'b1, addr), o_rdata);
  endtask

  task automatic reset_and_first_load();
    int lat;
    compare_word("reset busy", 64'd0, 64'(o_busy));
    compare_word("reset data_ok", 64'd0, 64'(o_data_ok));
    compare_word("reset rd_req", 64'd0, 64'(o_rd_req));
    compare_word("reset wr_req", 64'd0, 64'(o_wr_req));
    access("first_load", 1'b0, 32'h1000_0048, '0, '0, lat);
    compare_word("first_load rd count", 64'd1, 64'(rd_cnt));
    compare_word("first_load rd addr", 64'h1000_0040, 64'(last_rd_addr));
  endtask

  task automatic repeat_load_hit();
    int lat;
    access("repeat_hit", 1'b0, 32'h1000_0050, '0, '0, lat);
    compare_word("repeat_hit rd count", 64'd1, 64'(rd_cnt));
    compare_word("repeat_hit latency", 64'd1, 64'(lat));
  endtask

  task automatic store_merge();
    int lat;
    access("store_merge", 1'b1, 32'h1000_0058, 8'h3C, 64'h1122_3344_5566_7788, lat);
    compare_word("store_merge store latency", 64'd1, 64'(lat));
    access("store_merge", 1'b0, 32'h1000_0058, '0, '0, lat);
    compare_word("store_merge load latency", 64'd1, 64'(lat));
    compare_word("store_merge rd count", 64'd1, 64'(rd_cnt));
    compare_word("store_merge wr count", 64'd0, 64'(wr_cnt));
  endtask

  task automatic evict_dirty_victim();
    int lat;
    access("evict_dirty", 1'b0, 32'h1000_0840, '0, '0, lat);  // way 1 still invalid
    compare_word("evict_dirty wr count", 64'd0, 64'(wr_cnt));
    // set 2 has seen two fills, so its round-robin bit names way 0 (dirty tag of 0x1000_0040)
    access("evict_dirty", 1'b1, 32'h1000_1050, 8'hFF, 64'hCAFE_F00D_0BAD_BEEF, lat);
    compare_word("evict_dirty wr count", 64'd1, 64'(wr_cnt));
    compare_word("evict_dirty wr addr", 64'h1000_0040, 64'(last_wr_addr));
    for (int k = 0; k < 4; k++) begin
      compare_word("evict_dirty wr data", word_at(1'b1, 32'h1000_0040 + 32'(k * 8)),
                   last_wr_data[k*64 +: 64]);
    end
    require("evict_dirty", wr_seq < rd_seq, "write-back did not come before the refill");
    compare_word("evict_dirty rd addr", 64'h1000_1040, 64'(last_rd_addr));
    access("evict_dirty", 1'b0, 32'h1000_0840, '0, '0, lat);
    compare_word("evict_dirty kept way latency", 64'd1, 64'(lat));
    access("evict_dirty", 1'b0, 32'h1000_1050, '0, '0, lat);
    compare_word("evict_dirty new line latency", 64'd1, 64'(lat));
  endtask

  task automatic random_traffic();
    int          lat;
    logic [31:0] r;
    logic [31:0] a;
    rand_delay = 1'b1;
    for (int n = 0; n < RAND_ACCESS; n++) begin
      r = $random(seed);
      a = 32'h1000_0040 + (r & 32'h0000_1838);               // four tags, sets 2 and 3
      r = $random(seed);
      access("random_traffic", r[0], a, r[15:8], {$random(seed), $random(seed)}, lat);
    end
  endtask

  initial begin : watchdog
    #((NUM_ACCESS * 200 + RST_CYCLES) * CLK_PERIOD);
    $display("timeout: the cache did not finish %0d accesses in time", NUM_ACCESS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : stimulus
    int total;
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_op        = 1'b0;
    i_addr      = '0;
    i_wstrb     = '0;
    i_wdata     = '0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    i_wr_rdy    = 1'b0;
    repeat (RST_CYCLES) @(posedge i_clk);
    #2;
    i_rst = 1'b0;
    reset_and_first_load();
    repeat_load_hit();
    store_merge();
    evict_dirty_victim();
    random_traffic();
    total = value_errs + other_errs + u_dcache_top.u_ctrl.u_assertions.fails;
    $display("errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
             u_dcache_top.u_ctrl.u_assertions.fails);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
